// ==== src/pipe_ctl_cfg.svh ====
// pipeline control configuration
// reset vector, opcode values, multiply delay and instruction width

`ifndef PIPE_CTL_CFG_SVH
`define PIPE_CTL_CFG_SVH

// instruction and address width
`define CTL_INS_W 32

`define CTL_RESET_PC 32'h0000_0100 // first fetch address after reset

// last value of the multiply delay count, so a mul sits 33 cycles in its state
`define CTL_MUL_DELAY 32

// opcodes seen by the classifier, bits 31:26
`define CTL_OP_MUL  6'h1c
`define CTL_OP_LD   6'h23
`define CTL_OP_SYNC 6'h2f
`define CTL_OP_RET  6'h10

`define CTL_NOP_INS 32'h0000_0000 // all-zero word

`endif

// ==== src/pipe_ctl_pkg.sv ====
// pipeline control types
// width typedefs, command/state/pc-select enums and stage structs

`include "pipe_ctl_cfg.svh"

package pipe_ctl_pkg;

    typedef logic [`CTL_INS_W-1:0] word_t; // instruction word or address
    typedef logic [5:0] dly_t;             // multi-cycle delay count

    // command from the ID-stage classifier
    typedef enum logic [2:0] {
        CMD_NOI,
        CMD_CUR, // hold current instruction one slot
        CMD_MUL,
        CMD_LD,
        CMD_RET
    } id_cmd_e;

    typedef enum logic [2:0] {
        ST_RST,
        ST_IDLE,
        ST_NOI,
        ST_CUR,
        ST_MUL,
        ST_LD,
        ST_RET
    } ctl_state_e;

    typedef enum logic [1:0] {
        PC_RST, // load reset vector
        PC_KEP, // keep current pc
        PC_IGN  // step by 4
    } pc_sel_e;

    typedef struct packed {
        logic    nop;
        id_cmd_e cmd;
    } ctl_word_t;

    // one pipeline slot
    typedef struct packed {
        ctl_word_t ctl;
        word_t     pc;
        word_t     ins;
    } stage_t;

    typedef struct packed {
        logic    ins_clr;
        logic    ins_hold;
        logic    ctl_clr;
        logic    ctl_hold;
        logic    exec_clr;
        pc_sel_e pc_sel;
    } pipe_ctl_t;

endpackage

// ==== src/stall_timer.sv ====
// stall timer
// counts advancing cycles spent in a delay state of the control FSM,
// flags the last one and sits at zero otherwise

`timescale 1ns/10ps

`include "pipe_ctl_cfg.svh"

module stall_timer (
    input  logic clk,
    input  logic rst,
    input  logic advance,
    input  logic dly_run,
    output logic dly_done
);
    import pipe_ctl_pkg::*;

    dly_t dly_cnt;

    // more delay states only need to drive dly_run
    assign dly_done = dly_run && (dly_cnt == dly_t'(`CTL_MUL_DELAY));

    always_ff @(posedge clk) begin
        if (!rst) begin
            dly_cnt <= '0;
        end else if (advance) begin
            if (dly_run && !dly_done) begin
                dly_cnt <= dly_cnt + dly_t'(1);
            end else begin
                dly_cnt <= '0; // wraps on the last cycle so the next run starts clean
            end
        end
    end

endmodule

// ==== src/pipe_ctl_fsm.sv ====
// pipeline control FSM
// Moore machine that turns the ID-stage command into clear/hold strobes
// for the stage registers and the next-pc selection

`timescale 1ns/10ps

module pipe_ctl_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,
    input  pipe_ctl_pkg::id_cmd_e  id_cmd,
    input  logic                   dly_done,
    output logic                   dly_run,
    output pipe_ctl_pkg::pipe_ctl_t ctl
);
    import pipe_ctl_pkg::*;

    ctl_state_e cur_state;
    ctl_state_e next_state;
    ctl_state_e dispatch_state;

    // state register, frozen while the pipe is not advancing
    always_ff @(posedge clk) begin
        if (!rst) begin
            cur_state <= ST_RST;
        end else if (advance) begin
            cur_state <= next_state;
        end
    end

    // where an ordinary slot goes for the command now in ID
    always_comb begin
        case (id_cmd)
            CMD_NOI: dispatch_state = ST_NOI;
            CMD_CUR: dispatch_state = ST_CUR;
            CMD_MUL: dispatch_state = ST_MUL;
            CMD_LD:  dispatch_state = ST_LD;
            CMD_RET: dispatch_state = ST_RET;
            default: dispatch_state = ST_IDLE;
        endcase
    end

    always_comb begin
        case (cur_state)
            ST_RST:  next_state = ST_IDLE;
            ST_IDLE: next_state = dispatch_state;
            ST_NOI:  next_state = dispatch_state;
            ST_CUR:  next_state = ST_NOI;  // held instruction moves on next
            ST_LD:   next_state = ST_IDLE;
            ST_RET:  next_state = ST_IDLE;
            ST_MUL:  next_state = dly_done ? ST_IDLE : ST_MUL;
            default: next_state = ST_IDLE;
        endcase
    end

    assign dly_run = (cur_state == ST_MUL);

    // outputs from state only
    always_comb begin
        ctl.ins_clr  = 1'b0;
        ctl.ins_hold = 1'b0;
        ctl.ctl_clr  = 1'b0;
        ctl.ctl_hold = 1'b0;
        ctl.exec_clr = 1'b0;
        ctl.pc_sel   = PC_IGN;
        case (cur_state)
            ST_RST: begin
                ctl.ins_clr  = 1'b1;
                ctl.ctl_clr  = 1'b1;
                ctl.exec_clr = 1'b1;
                ctl.pc_sel   = PC_RST;
            end
            ST_MUL, ST_LD: begin
                // bubble into RA, fetch waits
                ctl.ins_clr = 1'b1;
                ctl.ctl_clr = 1'b1;
                ctl.pc_sel  = PC_KEP;
            end
            ST_CUR: begin
                ctl.ins_hold = 1'b1;
                ctl.ctl_hold = 1'b1;
                ctl.exec_clr = 1'b1; // RA kept, so EXEC gets the bubble
                ctl.pc_sel   = PC_KEP;
            end
            default: begin
                // idle, noi and ret all step the pc
                ctl.pc_sel = PC_IGN;
            end
        endcase
    end

endmodule

// ==== src/pc_gen.sv ====
// program counter
// loads the reset vector, keeps its value or steps by one word
// as the control FSM selects

`timescale 1ns/10ps

`include "pipe_ctl_cfg.svh"

module pc_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  pipe_ctl_pkg::pc_sel_e pc_sel,
    output pipe_ctl_pkg::word_t   fetch_pc
);
    import pipe_ctl_pkg::*;

    word_t pc_q;
    word_t pc_next;

    always_comb begin
        case (pc_sel)
            PC_RST:  pc_next = `CTL_RESET_PC;
            PC_KEP:  pc_next = pc_q;
            PC_IGN:  pc_next = pc_q + word_t'(4);
            default: pc_next = pc_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_q <= `CTL_RESET_PC;
        end else if (advance) begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

endmodule

// ==== src/ins_classify.sv ====
// ID-stage classifier
// decodes the opcode into a pipeline command and builds the control
// word that travels with the instruction

`timescale 1ns/10ps

`include "pipe_ctl_cfg.svh"

module ins_classify (
    input  pipe_ctl_pkg::word_t     id_ins,
    input  logic                    id_valid,
    output pipe_ctl_pkg::id_cmd_e   id_cmd,
    output pipe_ctl_pkg::ctl_word_t id_ctl
);
    import pipe_ctl_pkg::*;

    logic [5:0] opcode;

    assign opcode = id_ins[31:26];

    always_comb begin
        if (!id_valid) begin
            id_cmd = CMD_NOI; // empty slot behaves as ordinary
        end else begin
            case (opcode)
                `CTL_OP_MUL:  id_cmd = CMD_MUL;
                `CTL_OP_LD:   id_cmd = CMD_LD;
                `CTL_OP_SYNC: id_cmd = CMD_CUR;
                `CTL_OP_RET:  id_cmd = CMD_RET;
                default:      id_cmd = CMD_NOI;
            endcase
        end
    end

    // nop marks both empty slots and the all-zero word
    assign id_ctl.nop = !id_valid || (id_ins == `CTL_NOP_INS);
    assign id_ctl.cmd = id_cmd;

endmodule

// ==== src/pipe_regs.sv ====
// pipeline stage registers
// ID slot from fetch, RA slot with separate instruction/control clear
// and hold, EXEC slot with its own clear

`timescale 1ns/10ps

`include "pipe_ctl_cfg.svh"

module pipe_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  pipe_ctl_pkg::word_t     fetch_pc,
    input  pipe_ctl_pkg::word_t     fetch_ins,
    input  pipe_ctl_pkg::ctl_word_t id_ctl,
    input  pipe_ctl_pkg::pipe_ctl_t ctl,
    output pipe_ctl_pkg::stage_t    id_slot,
    output pipe_ctl_pkg::stage_t    exec_bundle
);
    import pipe_ctl_pkg::*;

    localparam ctl_word_t nop_ctl   = '{nop: 1'b1, cmd: CMD_NOI};
    localparam ctl_word_t valid_ctl = '{nop: 1'b0, cmd: CMD_NOI};

    ctl_word_t id_ctl_q, ra_ctl_q, ex_ctl_q;
    word_t     id_pc_q, ra_pc_q, ex_pc_q;
    word_t     id_ins_q, ra_ins_q, ex_ins_q;

    // ID slot control, only marks whether a fetched word is present
    always_ff @(posedge clk) begin
        if (!rst) begin
            id_ctl_q <= nop_ctl;
        end else if (advance) begin
            case (ctl.pc_sel)
                PC_IGN:  id_ctl_q <= valid_ctl;
                PC_RST:  id_ctl_q <= nop_ctl;
                default: id_ctl_q <= id_ctl_q; // pc kept, ID waits too
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (advance && ctl.pc_sel == PC_IGN) begin
            id_pc_q  <= fetch_pc;
            id_ins_q <= fetch_ins;
        end
    end

    // RA slot
    always_ff @(posedge clk) begin
        if (!rst) begin
            ra_ctl_q <= nop_ctl;
        end else if (advance) begin
            if (ctl.ctl_clr) begin
                ra_ctl_q <= nop_ctl;
            end else if (!ctl.ctl_hold) begin
                ra_ctl_q <= id_ctl;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (ctl.ins_clr) begin
                ra_pc_q  <= '0;
                ra_ins_q <= `CTL_NOP_INS;
            end else if (!ctl.ins_hold) begin
                ra_pc_q  <= id_pc_q;
                ra_ins_q <= id_ins_q;
            end
        end
    end

    // EXEC slot
    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_ctl_q <= nop_ctl;
        end else if (advance) begin
            ex_ctl_q <= ctl.exec_clr ? nop_ctl : ra_ctl_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ex_pc_q  <= ctl.exec_clr ? '0 : ra_pc_q;
            ex_ins_q <= ctl.exec_clr ? `CTL_NOP_INS : ra_ins_q;
        end
    end

    assign id_slot     = '{ctl: id_ctl_q, pc: id_pc_q, ins: id_ins_q};
    assign exec_bundle = '{ctl: ex_ctl_q, pc: ex_pc_q, ins: ex_ins_q};

endmodule

// ==== src/pipe_ctl_top.sv ====
// pipeline control top level
// fetch pc, ID classifier, control FSM, stall timer and stage registers

`timescale 1ns/10ps

module pipe_ctl_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,   // global enable, low freezes everything
    input  pipe_ctl_pkg::word_t  fetch_ins,
    output pipe_ctl_pkg::word_t  fetch_pc,
    output pipe_ctl_pkg::stage_t exec_bundle
);
    import pipe_ctl_pkg::*;

    stage_t    id_slot;
    id_cmd_e   id_cmd;
    ctl_word_t id_ctl;
    pipe_ctl_t ctl;
    logic      dly_run;
    logic      dly_done;

    stall_timer stall_timer_i (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .dly_run  (dly_run),
        .dly_done (dly_done)
    );

    pipe_ctl_fsm pipe_ctl_fsm_i (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .id_cmd   (id_cmd),
        .dly_done (dly_done),
        .dly_run  (dly_run),
        .ctl      (ctl)
    );

    pc_gen pc_gen_i (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .pc_sel   (ctl.pc_sel),
        .fetch_pc (fetch_pc)
    );

    ins_classify ins_classify_i (
        .id_ins   (id_slot.ins),
        .id_valid (!id_slot.ctl.nop),
        .id_cmd   (id_cmd),
        .id_ctl   (id_ctl)
    );

    pipe_regs pipe_regs_i (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .fetch_pc    (fetch_pc),
        .fetch_ins   (fetch_ins),
        .id_ctl      (id_ctl),
        .ctl         (ctl),
        .id_slot     (id_slot),
        .exec_bundle (exec_bundle)
    );

endmodule

// ==== test/tb_pipe_ctl.sv ====
// pipeline control testbench
// drives programs from an instruction memory model through the pipeline
// and checks the EXEC stream against a reference model, with and without
// random stalls on advance

`timescale 1ns/10ps

`include "pipe_ctl_cfg.svh"

module tb_pipe_ctl;
    import pipe_ctl_pkg::*;

    localparam int PROG_MAX = 64;

    logic   clk;
    logic   rst;
    logic   advance;
    word_t  fetch_ins;
    word_t  fetch_pc;
    stage_t exec_bundle;

    // program memory, words past the end read as nop
    word_t prog [0:PROG_MAX-1];
    int    prog_len;
    word_t mem_off;

    // expected EXEC stream
    word_t   exp_pc  [0:PROG_MAX-1];
    word_t   exp_ins [0:PROG_MAX-1];
    id_cmd_e exp_cmd [0:PROG_MAX-1];
    int      exp_bub [0:PROG_MAX-1];
    logic    exp_mul [0:PROG_MAX-1];
    int      exp_len;

    logic [31:0] lfsr_q;
    logic        adv_random;

    // monitor state
    int     obs_idx;
    int     bubble_cnt;
    int     mul_left;
    word_t  mul_pc;
    word_t  last_pc;
    stage_t last_ex;
    logic   prev_rst;
    logic   prev_adv;

    pipe_ctl_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .advance     (advance),
        .fetch_ins   (fetch_ins),
        .fetch_pc    (fetch_pc),
        .exec_bundle (exec_bundle)
    );

    assign mem_off   = fetch_pc - word_t'(`CTL_RESET_PC);
    assign fetch_ins = (mem_off < word_t'(prog_len * 4)) ? prog[mem_off[7:2]] : `CTL_NOP_INS;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stop_sim(input string reason);
        if (reason != "") begin
            $display("%s", reason);
        end
        $display("Simulation failed");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
            stop_sim("");
        end
    endtask

    task automatic add_fill();
        logic [31:0] low;
        logic [31:0] op;
        low = take_bits(26);
        op = take_bits(6);
        // keep fill ordinary and never the nop word
        if (op[5:0] == `CTL_OP_MUL || op[5:0] == `CTL_OP_LD || op[5:0] == `CTL_OP_SYNC ||
            op[5:0] == `CTL_OP_RET || op[5:0] == 6'h00) begin
            op[5:0] = 6'h08;
        end
        prog[prog_len] = {op[5:0], low[25:0]};
        prog_len++;
    endtask

    task automatic add_op(input logic [5:0] op);
        logic [31:0] low;
        low = take_bits(26);
        prog[prog_len] = {op, low[25:0]};
        prog_len++;
    endtask

    // walks the program by the command rules
    function automatic void expected_stream();
        int          pending;
        logic        skip;
        logic [5:0]  op;
        int          i;
        pending = 3; // reset vector load plus ID and RA before the first word
        skip = 1'b0;
        for (i = 0; i < prog_len; i++) begin
            op = prog[i][31:26];
            exp_pc[i]  = word_t'(`CTL_RESET_PC) + (word_t'(i) << 2);
            exp_ins[i] = prog[i];
            exp_bub[i] = pending;
            exp_mul[i] = 1'b0;
            case (op)
                `CTL_OP_MUL:  exp_cmd[i] = CMD_MUL;
                `CTL_OP_LD:   exp_cmd[i] = CMD_LD;
                `CTL_OP_SYNC: exp_cmd[i] = CMD_CUR;
                `CTL_OP_RET:  exp_cmd[i] = CMD_RET;
                default:      exp_cmd[i] = CMD_NOI;
            endcase
            pending = 0;
            if (skip) begin
                skip = 1'b0; // ret state does not dispatch the word after it
            end else if (op == `CTL_OP_SYNC) begin
                exp_bub[i] = exp_bub[i] + 1;
            end else if (op == `CTL_OP_MUL) begin
                pending = `CTL_MUL_DELAY + 1;
                exp_mul[i] = 1'b1;
            end else if (op == `CTL_OP_LD) begin
                pending = 1;
            end else if (op == `CTL_OP_RET) begin
                skip = 1'b1;
            end
        end
        exp_len = prog_len;
    endfunction

    // advance driver
    initial begin
        logic [31:0] bits;
        forever begin
            @(negedge clk);
            if (adv_random && rst) begin
                bits = take_bits(2);
                advance = (bits[1:0] != 2'b00); // stalls about a quarter of cycles
            end else begin
                advance = 1'b1;
            end
        end
    end

    // monitor, samples at the rising edge what the previous edge produced
    always @(posedge clk) begin
        if (prev_rst && !prev_adv) begin
            check_value("fetch_pc (stalled)", 64'(fetch_pc), 64'(last_pc));
            check_value("exec_bundle.pc (stalled)", 64'(exec_bundle.pc), 64'(last_ex.pc));
            check_value("exec_bundle.ins (stalled)", 64'(exec_bundle.ins), 64'(last_ex.ins));
            check_value("exec_bundle.ctl (stalled)", 64'(exec_bundle.ctl), 64'(last_ex.ctl));
        end else if (prev_rst && prev_adv) begin
            if (mul_left > 0) begin
                check_value("fetch_pc during mul", 64'(fetch_pc), 64'(mul_pc));
                mul_left--;
            end
            if (exec_bundle.ctl.nop) begin
                bubble_cnt++;
            end else if (obs_idx >= exp_len) begin
                stop_sim("an instruction reached EXEC after the end of the program");
            end else begin
                check_value("bubbles before entry", 64'(bubble_cnt), 64'(exp_bub[obs_idx]));
                check_value("exec_bundle.pc", 64'(exec_bundle.pc), 64'(exp_pc[obs_idx]));
                check_value("exec_bundle.ins", 64'(exec_bundle.ins), 64'(exp_ins[obs_idx]));
                check_value("exec_bundle.ctl.cmd", 64'(exec_bundle.ctl.cmd),
                            64'(exp_cmd[obs_idx]));
                if (exp_mul[obs_idx]) begin
                    mul_left = `CTL_MUL_DELAY;
                    mul_pc = exp_pc[obs_idx] + word_t'(8); // fetch waits two words ahead
                end
                obs_idx++;
                bubble_cnt = 0;
            end
        end
        last_pc  = fetch_pc;
        last_ex  = exec_bundle;
        prev_rst = rst;
        prev_adv = advance;
        if (!rst) begin
            obs_idx = 0;
            bubble_cnt = 0;
            mul_left = 0;
        end
    end

    task automatic run_program(input logic rand_adv);
        int n;
        expected_stream();
        @(negedge clk);
        rst = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        check_value("fetch_pc after reset", 64'(fetch_pc), 64'(`CTL_RESET_PC));
        check_value("exec_bundle.ctl.nop after reset", 64'(exec_bundle.ctl.nop), 64'(1));
        adv_random = rand_adv; // random stalls start at the next falling edge
        n = 0;
        while (obs_idx < exp_len && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (obs_idx < exp_len) begin
            stop_sim("timed out waiting for the EXEC stream to complete");
        end
        repeat (60) @(negedge clk); // trailing slots must stay empty
        @(posedge clk);
        adv_random = 1'b0;
    endtask

    initial begin
        rst = 1'b0;
        advance = 1'b1;
        adv_random = 1'b0;
        lfsr_q = 32'h283e_4c30;
        prog_len = 0;
        exp_len = 0;
        obs_idx = 0;
        bubble_cnt = 0;
        mul_left = 0;
        mul_pc = '0;
        prev_rst = 1'b0;
        prev_adv = 1'b0;

        // ordinary stream
        repeat (16) add_fill();
        run_program(1'b0);
        run_program(1'b1);

        // mixed stream with every command
        prog_len = 0;
        add_fill();
        add_op(`CTL_OP_MUL);
        add_fill();
        add_op(`CTL_OP_LD);
        add_fill();
        add_op(`CTL_OP_SYNC);
        add_fill();
        add_fill();
        add_op(`CTL_OP_RET);
        add_op(`CTL_OP_MUL); // follows ret, runs as ordinary
        add_fill();
        add_op(`CTL_OP_SYNC);
        add_op(`CTL_OP_SYNC);
        add_op(`CTL_OP_LD);
        add_op(`CTL_OP_MUL);
        add_op(`CTL_OP_MUL);
        add_op(`CTL_OP_SYNC);
        add_fill();
        add_op(`CTL_OP_RET);
        add_fill();
        add_fill();
        run_program(1'b0);
        run_program(1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/pipe_ctl_pkg.sv
src/stall_timer.sv
src/pipe_ctl_fsm.sv
src/pc_gen.sv
src/ins_classify.sv
src/pipe_regs.sv
src/pipe_ctl_top.sv
test/tb_pipe_ctl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_pipe_ctl -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi
if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
echo "no result found in sim.log"
exit 1
